// File: hw/lwb_pkg.sv
`default_nettype none

package lwb_pkg;

    // ------------------------------------------------------------------------
    // sizing
    // ------------------------------------------------------------------------
    localparam int DMEM_ADDR_W = 8;                 // word index width
    localparam int DMEM_DEPTH  = 1 << DMEM_ADDR_W;  // 256 words
    localparam int RF_ADDR_W   = 5;                 // register number width

    // ------------------------------------------------------------------------
    // operation kinds arriving from execute
    // ------------------------------------------------------------------------
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_ALU = 4'd1,
        OP_SW  = 4'd2,
        OP_LB  = 4'd3,
        OP_LBU = 4'd4,
        OP_LH  = 4'd5,
        OP_LHU = 4'd6,
        OP_LW  = 4'd7,
        OP_LWL = 4'd8,
        OP_LWR = 4'd9
    } lwb_op_e;

    // writeback source
    typedef enum logic [1:0] {
        SEL_NONE  = 2'd0,  // no register write
        SEL_ALU   = 2'd1,  // passed alu result
        SEL_EXT   = 2'd2,  // extended load
        SEL_MERGE = 2'd3   // rotated partial load
    } wb_sel_e;

    // extension control for ordinary loads
    typedef enum logic [2:0] {
        EXT_B  = 3'd0,
        EXT_BU = 3'd1,
        EXT_H  = 3'd2,
        EXT_HU = 3'd3,
        EXT_W  = 3'd4
    } ext_ctl_e;

    // one data word seen as bytes or as halfwords, lane 0 at bits 7:0
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } mem_word_u;

endpackage

`default_nettype wire

// File: hw/load_extend.sv
`timescale 1ns/10ps
`default_nettype none

module load_extend import lwb_pkg::*; (
    input  wire [31:0] word,    // raw memory word
    input  wire [1:0]  adrl,    // low address bits
    input  wire ext_ctl_e ext,
    output logic [31:0] ext_out
);

    mem_word_u w;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign w = word;

    // lane picks, halfword chosen by address bit 1
    assign sel_byte = w.b[adrl];
    assign sel_half = w.h[adrl[1]];

    always_comb begin
        case (ext)
            EXT_B: begin
                ext_out = {{24{sel_byte[7]}}, sel_byte};
            end
            EXT_BU: begin
                ext_out = {24'd0, sel_byte};
            end
            EXT_H: begin
                ext_out = {{16{sel_half[15]}}, sel_half};
            end
            EXT_HU: begin
                ext_out = {16'd0, sel_half};
            end
            default: begin
                ext_out = word;  // lw, low bits ignored
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage import lwb_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n,
    // execute strobe and fields
    input  wire                    ex_valid,
    input  wire [31:0]             ex_pc,
    input  wire lwb_op_e           ex_op,
    input  wire [31:0]             ex_addr,
    input  wire [31:0]             ex_result,
    input  wire [31:0]             ex_store_data,
    input  wire [RF_ADDR_W-1:0]    ex_wnum,
    // data memory port
    output logic                   ram_en,
    output logic                   ram_we,
    output logic [DMEM_ADDR_W-1:0] ram_addr,
    output logic [31:0]            ram_wdata,
    // toward writeback
    output logic                   m_valid,
    output logic [31:0]            m_pc,
    output wb_sel_e                m_sel,
    output ext_ctl_e               m_ext,
    output logic [1:0]             m_adrl,
    output logic [1:0]             m_rot,    // rotate left, in bytes
    output logic [3:0]             m_bmask,  // merge lanes
    output logic [31:0]            m_result,
    output logic [RF_ADDR_W-1:0]   m_wnum
);

    lwb_op_e     op_r;
    logic [31:0] addr_r;
    logic [31:0] store_r;
    logic        is_load;

    // ------------------------------------------------------------------------
    // stage registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
            op_r    <= OP_NOP;
        end else begin
            m_valid <= ex_valid;
            op_r    <= ex_valid ? ex_op : OP_NOP;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            m_pc     <= ex_pc;
            addr_r   <= ex_addr;
            m_result <= ex_result;
            store_r  <= ex_store_data;
            m_wnum   <= ex_wnum;
        end
    end

    // ------------------------------------------------------------------------
    // memory access, issued at the end of this cycle
    // ------------------------------------------------------------------------
    assign is_load   = (op_r >= OP_LB) && (op_r <= OP_LWR);
    assign ram_we    = m_valid && (op_r == OP_SW);
    assign ram_en    = m_valid && (is_load || op_r == OP_SW);
    assign ram_addr  = addr_r[DMEM_ADDR_W+1:2];  // word index
    assign ram_wdata = store_r;
    assign m_adrl    = addr_r[1:0];

    // load shaping controls
    always_comb begin
        m_sel   = SEL_NONE;
        m_ext   = EXT_W;
        m_rot   = 2'd0;
        m_bmask = 4'b0000;
        case (op_r)
            OP_ALU: m_sel = SEL_ALU;
            OP_LB:  begin
                m_sel = SEL_EXT;
                m_ext = EXT_B;
            end
            OP_LBU: begin
                m_sel = SEL_EXT;
                m_ext = EXT_BU;
            end
            OP_LH:  begin
                m_sel = SEL_EXT;
                m_ext = EXT_H;
            end
            OP_LHU: begin
                m_sel = SEL_EXT;
                m_ext = EXT_HU;
            end
            OP_LW:  m_sel = SEL_EXT;
            OP_LWL: begin
                m_sel   = SEL_MERGE;
                m_rot   = 2'd3 - addr_r[1:0];             // left by 3-a
                m_bmask = 4'b1111 << (2'd3 - addr_r[1:0]); // lanes 3-a..3
            end
            OP_LWR: begin
                m_sel   = SEL_MERGE;
                m_rot   = 2'd0 - addr_r[1:0];  // right by a
                m_bmask = 4'b1111 >> addr_r[1:0];
            end
            default: ;  // nop and sw write nothing
        endcase
    end

endmodule

`default_nettype wire

// File: hw/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

module data_ram import lwb_pkg::*; (
    input  wire                   clk,
    input  wire                   en,
    input  wire                   we,
    input  wire [DMEM_ADDR_W-1:0] addr,
    input  wire [31:0]            wdata,
    output logic [31:0]           rdata
);

    logic [31:0] mem [DMEM_DEPTH];

    // ------------------------------------------------------------------------
    // single port, write-first
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (en && we) begin
            mem[addr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                rdata <= wdata;      // new data seen on same address
            end else begin
                rdata <= mem[addr];
            end
        end
        // rdata holds while idle
    end

endmodule

`default_nettype wire

// File: hw/wb_stage.sv
`timescale 1ns/10ps
`default_nettype none

module wb_stage import lwb_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,
    // from memory stage
    input  wire                  m_valid,
    input  wire [31:0]           m_pc,
    input  wire wb_sel_e         m_sel,
    input  wire ext_ctl_e        m_ext,
    input  wire [1:0]            m_adrl,
    input  wire [1:0]            m_rot,
    input  wire [3:0]            m_bmask,
    input  wire [31:0]           m_result,
    input  wire [RF_ADDR_W-1:0]  m_wnum,
    input  wire [31:0]           ram_rdata,  // arrives with the registered controls
    // register file write
    output logic [3:0]           rf_we,
    output logic [RF_ADDR_W-1:0] rf_wnum,
    output logic [31:0]          rf_wdata,
    // writeback trace
    output logic [31:0]          debug_wb_pc,
    output logic [3:0]           debug_wb_rf_wen,
    output logic [RF_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [31:0]          debug_wb_rf_wdata
);

    logic [31:0]          pc_r;
    wb_sel_e              sel_r;
    ext_ctl_e             ext_r;
    logic [1:0]           adrl_r;
    logic [1:0]           rot_r;
    logic [3:0]           bmask_r;
    logic [31:0]          result_r;
    logic [RF_ADDR_W-1:0] wnum_r;

    mem_word_u   rd_word;
    mem_word_u   merge_word;
    logic [31:0] ext_word;

    // ------------------------------------------------------------------------
    // stage registers, inactive when nothing valid arrives
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n || !m_valid) begin
            pc_r     <= 32'd0;
            sel_r    <= SEL_NONE;
            ext_r    <= EXT_W;
            adrl_r   <= 2'd0;
            rot_r    <= 2'd0;
            bmask_r  <= 4'b0000;
            result_r <= 32'd0;
            wnum_r   <= '0;
        end else begin
            pc_r     <= m_pc;
            sel_r    <= m_sel;
            ext_r    <= m_ext;
            adrl_r   <= m_adrl;
            rot_r    <= m_rot;
            bmask_r  <= m_bmask;
            result_r <= m_result;
            wnum_r   <= m_wnum;
        end
    end

    assign rd_word = ram_rdata;

    load_extend u_load_extend (
        .word    (ram_rdata),
        .adrl    (adrl_r),
        .ext     (ext_r),
        .ext_out (ext_word)
    );

    // byte rotate left for lwl / lwr
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merge_word.b[i] = rd_word.b[2'(i - int'(rot_r))];
        end
    end

    // ------------------------------------------------------------------------
    // writeback data and byte enables
    // ------------------------------------------------------------------------
    always_comb begin
        case (sel_r)
            SEL_ALU: begin
                rf_we    = 4'b1111;
                rf_wdata = result_r;
            end
            SEL_EXT: begin
                rf_we    = 4'b1111;
                rf_wdata = ext_word;
            end
            SEL_MERGE: begin
                rf_we    = bmask_r;  // partial lanes only
                rf_wdata = merge_word;
            end
            default: begin
                rf_we    = 4'b0000;
                rf_wdata = 32'd0;
            end
        endcase
    end

    assign rf_wnum = wnum_r;

    // trace, updated every cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            debug_wb_pc       <= 32'd0;
            debug_wb_rf_wen   <= 4'b0000;
            debug_wb_rf_wnum  <= '0;
            debug_wb_rf_wdata <= 32'd0;
        end else begin
            debug_wb_pc       <= pc_r;
            debug_wb_rf_wen   <= rf_we;
            debug_wb_rf_wnum  <= rf_wnum;
            debug_wb_rf_wdata <= rf_wdata;
        end
    end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file import lwb_pkg::*; (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire [3:0]           we,     // one per byte lane
    input  wire [RF_ADDR_W-1:0] wnum,
    input  wire [31:0]          wdata,
    input  wire [RF_ADDR_W-1:0] raddr,
    output logic [31:0]         rdata
);

    logic [3:0][7:0] regs [1 << RF_ADDR_W];

    // ------------------------------------------------------------------------
    // byte-lane writes, r0 never written
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < (1 << RF_ADDR_W); r++) begin
                regs[r] <= '0;
            end
        end else if (wnum != '0) begin
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    regs[wnum][i] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // combinational read
    assign rdata = regs[raddr];

endmodule

`default_nettype wire

// File: hw/load_wb_top.sv
`timescale 1ns/10ps
`default_nettype none

module load_wb_top import lwb_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  ex_valid,
    input  wire [31:0]           ex_pc,
    input  wire lwb_op_e         ex_op,
    input  wire [31:0]           ex_addr,
    input  wire [31:0]           ex_result,
    input  wire [31:0]           ex_store_data,
    input  wire [RF_ADDR_W-1:0]  ex_wnum,
    input  wire [RF_ADDR_W-1:0]  rf_raddr,
    output logic [31:0]          rf_rdata,
    output logic [31:0]          debug_wb_pc,
    output logic [3:0]           debug_wb_rf_wen,
    output logic [RF_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [31:0]          debug_wb_rf_wdata
);

    // memory port
    logic                   ram_en;
    logic                   ram_we;
    logic [DMEM_ADDR_W-1:0] ram_addr;
    logic [31:0]            ram_wdata;
    logic [31:0]            ram_rdata;

    // memory stage to writeback
    logic                   m_valid;
    logic [31:0]            m_pc;
    wb_sel_e                m_sel;
    ext_ctl_e               m_ext;
    logic [1:0]             m_adrl;
    logic [1:0]             m_rot;
    logic [3:0]             m_bmask;
    logic [31:0]            m_result;
    logic [RF_ADDR_W-1:0]   m_wnum;

    // writeback to register file
    logic [3:0]             rf_we;
    logic [RF_ADDR_W-1:0]   rf_wnum;
    logic [31:0]            rf_wdata;

    mem_stage u_mem_stage (
        .clk (clk), .rst_n (rst_n),
        .ex_valid (ex_valid), .ex_pc (ex_pc), .ex_op (ex_op), .ex_addr (ex_addr),
        .ex_result (ex_result), .ex_store_data (ex_store_data), .ex_wnum (ex_wnum),
        .ram_en (ram_en), .ram_we (ram_we), .ram_addr (ram_addr), .ram_wdata (ram_wdata),
        .m_valid (m_valid), .m_pc (m_pc), .m_sel (m_sel), .m_ext (m_ext),
        .m_adrl (m_adrl), .m_rot (m_rot), .m_bmask (m_bmask),
        .m_result (m_result), .m_wnum (m_wnum)
    );

    data_ram u_data_ram (
        .clk (clk), .en (ram_en), .we (ram_we),
        .addr (ram_addr), .wdata (ram_wdata), .rdata (ram_rdata)
    );

    wb_stage u_wb_stage (
        .clk (clk), .rst_n (rst_n),
        .m_valid (m_valid), .m_pc (m_pc), .m_sel (m_sel), .m_ext (m_ext),
        .m_adrl (m_adrl), .m_rot (m_rot), .m_bmask (m_bmask),
        .m_result (m_result), .m_wnum (m_wnum), .ram_rdata (ram_rdata),
        .rf_we (rf_we), .rf_wnum (rf_wnum), .rf_wdata (rf_wdata),
        .debug_wb_pc (debug_wb_pc), .debug_wb_rf_wen (debug_wb_rf_wen),
        .debug_wb_rf_wnum (debug_wb_rf_wnum), .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    reg_file u_reg_file (
        .clk (clk), .rst_n (rst_n),
        .we (rf_we), .wnum (rf_wnum), .wdata (rf_wdata),
        .raddr (rf_raddr), .rdata (rf_rdata)
    );

endmodule

`default_nettype wire

// File: tb/load_wb_chk.sv
`timescale 1ns/10ps
`default_nettype none

module load_wb_chk import lwb_pkg::*; (
    input wire          clk,
    input wire          rst_n,
    input wire wb_sel_e sel,  // registered writeback select
    input wire [3:0]    we
);

    int fail_cnt = 0;

    // ------------------------------------------------------------------------
    // byte enables against the writeback select
    // ------------------------------------------------------------------------
    no_write_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        sel == SEL_NONE |-> we == 4'b0000)
    else begin
        fail_cnt++;
        $error("byte enables active with no writeback select");
    end

    full_word_write: assert property (@(posedge clk) disable iff (!rst_n)
        (sel == SEL_ALU || sel == SEL_EXT) |-> we == 4'b1111)
    else begin
        fail_cnt++;
        $error("alu or extended load without all four lanes enabled");
    end

    // contiguous run anchored at lane 0 or lane 3
    merge_lanes: assert property (@(posedge clk) disable iff (!rst_n)
        sel == SEL_MERGE |-> we inside {4'b0001, 4'b0011, 4'b0111, 4'b1111,
                                        4'b1000, 4'b1100, 4'b1110})
    else begin
        fail_cnt++;
        $error("partial load lane mask is not an edge-anchored run");
    end

endmodule

bind wb_stage load_wb_chk u_load_wb_chk (
    .clk   (clk),
    .rst_n (rst_n),
    .sel   (sel_r),
    .we    (rf_we)
);

`default_nettype wire

// File: tb/load_wb_tb.sv
`timescale 1ns/10ps
`default_nettype none

module load_wb_tb import lwb_pkg::*; ();

    localparam int N_FILL  = DMEM_DEPTH;  // one store per word
    localparam int N_LOADS = 40;
    localparam int N_MIX   = 200;
    localparam int N_OPS   = N_FILL + N_LOADS + 40 + N_MIX + 5 * 32;  // incl. register sweeps

    typedef struct packed {
        logic [31:0]          pc;
        logic [3:0]           wen;
        logic [RF_ADDR_W-1:0] wnum;
        logic [31:0]          data;  // new register value, valid in enabled lanes
    } wb_rec_t;

    logic                 clk;
    logic                 rst_n;
    logic                 ex_valid;
    logic [31:0]          ex_pc;
    lwb_op_e              ex_op;
    logic [31:0]          ex_addr;
    logic [31:0]          ex_result;
    logic [31:0]          ex_store_data;
    logic [RF_ADDR_W-1:0] ex_wnum;
    logic [RF_ADDR_W-1:0] rf_raddr;
    logic [31:0]          rf_rdata;
    logic [31:0]          debug_wb_pc;
    logic [3:0]           debug_wb_rf_wen;
    logic [RF_ADDR_W-1:0] debug_wb_rf_wnum;
    logic [31:0]          debug_wb_rf_wdata;

    logic [31:0] mem_model [DMEM_DEPTH];
    logic [31:0] reg_model [1 << RF_ADDR_W];
    wb_rec_t     exp_q [$];
    logic [31:0] pc_next;
    int          errors;
    int          checks;

    load_wb_top load_wb_top_i (
        .clk (clk), .rst_n (rst_n),
        .ex_valid (ex_valid), .ex_pc (ex_pc), .ex_op (ex_op), .ex_addr (ex_addr),
        .ex_result (ex_result), .ex_store_data (ex_store_data), .ex_wnum (ex_wnum),
        .rf_raddr (rf_raddr), .rf_rdata (rf_rdata),
        .debug_wb_pc (debug_wb_pc), .debug_wb_rf_wen (debug_wb_rf_wen),
        .debug_wb_rf_wnum (debug_wb_rf_wnum), .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // reference model, returns {enables, merged register value}
    // ------------------------------------------------------------------------
    function automatic logic [35:0] expected_write(lwb_op_e op, logic [31:0] addr,
            logic [31:0] alu, logic [31:0] word, logic [31:0] old);
        int          ai;
        logic [63:0] dbl;
        logic [7:0]  byte_v;
        logic [15:0] half_v;
        logic [31:0] rot_l;
        logic [31:0] rot_r;
        logic [31:0] val;
        logic [3:0]  wen;
        ai     = int'(addr[1:0]);
        dbl    = {word, word};
        byte_v = word[8*ai +: 8];
        half_v = addr[1] ? word[31:16] : word[15:0];
        rot_l  = 32'((dbl << (8 * (3 - ai))) >> 32);  // left by 3-a bytes
        rot_r  = 32'(dbl >> (8 * ai));                 // right by a bytes
        case (op)
            OP_ALU:  val = alu;
            OP_LB:   val = {{24{byte_v[7]}}, byte_v};
            OP_LBU:  val = {24'd0, byte_v};
            OP_LH:   val = {{16{half_v[15]}}, half_v};
            OP_LHU:  val = {16'd0, half_v};
            OP_LW:   val = word;
            OP_LWL:  val = rot_l;
            OP_LWR:  val = rot_r;
            default: val = old;
        endcase
        wen = 4'b0000;
        for (int i = 0; i < 4; i++) begin
            case (op)
                OP_NOP, OP_SW: wen[i] = 1'b0;
                OP_LWL:        wen[i] = (i >= 3 - ai);  // lanes 3-a..3
                OP_LWR:        wen[i] = (i <= 3 - ai);  // lanes 0..3-a
                default:       wen[i] = 1'b1;
            endcase
        end
        for (int i = 0; i < 4; i++) begin
            if (!wen[i]) begin
                val[8*i +: 8] = old[8*i +: 8];  // lane keeps old contents
            end
        end
        return {wen, val};
    endfunction

    function automatic logic [31:0] lane_mask(logic [3:0] wen);
        return {{8{wen[3]}}, {8{wen[2]}}, {8{wen[1]}}, {8{wen[0]}}};
    endfunction

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    task automatic issue(lwb_op_e op, logic [31:0] addr, logic [31:0] result,
                         logic [31:0] sdata, int wnum_i);
        logic [RF_ADDR_W-1:0]   wnum;
        logic [DMEM_ADDR_W-1:0] idx;
        logic [35:0]            exp;
        wb_rec_t                rec;
        wnum = RF_ADDR_W'(wnum_i);
        idx  = addr[DMEM_ADDR_W+1:2];
        @(posedge clk);
        ex_valid      <= 1'b1;
        ex_pc         <= pc_next;
        ex_op         <= op;
        ex_addr       <= addr;
        ex_result     <= result;
        ex_store_data <= sdata;
        ex_wnum       <= wnum;
        exp = expected_write(op, addr, result, mem_model[idx], reg_model[wnum]);
        if (op == OP_SW) begin
            mem_model[idx] = sdata;
        end
        if (exp[35:32] != 4'b0000) begin
            rec.pc   = pc_next;
            rec.wen  = exp[35:32];
            rec.wnum = wnum;
            rec.data = exp[31:0];
            exp_q.push_back(rec);
            if (wnum != '0) begin
                reg_model[wnum] = exp[31:0];  // r0 stays zero
            end
        end
        pc_next = pc_next + 32'd4;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            ex_valid <= 1'b0;
            ex_op    <= OP_NOP;
        end
    endtask

    task automatic drain();
        idle(1);
        while (exp_q.size() != 0) begin
            idle(1);
        end
        idle(3);  // trailing stores settle
    endtask

    task automatic check_regs();
        for (int r = 0; r < (1 << RF_ADDR_W); r++) begin
            @(posedge clk);
            rf_raddr <= RF_ADDR_W'(r);
            @(negedge clk);
            checks++;
            assert (rf_rdata === reg_model[r]) else begin
                errors++;
                $display("error at %0t: r%0d reads %h, expected %h",
                         $time, r, rf_rdata, reg_model[r]);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // trace comparison, in order, between clock edges
    // ------------------------------------------------------------------------
    initial begin
        wb_rec_t rec;
        forever begin
            @(negedge clk);
            if (rst_n && debug_wb_rf_wen != 4'b0000) begin
                checks++;
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("trace shows a register write at %0t with nothing pending", $time);
                end
                if (exp_q.size() != 0) begin
                    rec = exp_q.pop_front();
                    checks++;
                    assert (debug_wb_pc == rec.pc && debug_wb_rf_wen == rec.wen &&
                            debug_wb_rf_wnum == rec.wnum &&
                            (debug_wb_rf_wdata & lane_mask(rec.wen)) ==
                            (rec.data & lane_mask(rec.wen))) else begin
                        errors++;
                        $display("error at %0t: pc %h wen %b r%0d data %h, expected %h %b r%0d %h",
                                 $time, debug_wb_pc, debug_wb_rf_wen, debug_wb_rf_wnum,
                                 debug_wb_rf_wdata, rec.pc, rec.wen, rec.wnum, rec.data);
                    end
                end
            end
        end
    end

    initial begin
        repeat (N_OPS * 20) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", N_OPS * 20);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(32'h8240));
        rst_n         = 1'b0;
        ex_valid      = 1'b0;
        ex_pc         = 32'd0;
        ex_op         = OP_NOP;
        ex_addr       = 32'd0;
        ex_result     = 32'd0;
        ex_store_data = 32'd0;
        ex_wnum       = '0;
        rf_raddr      = '0;
        errors        = 0;
        checks        = 0;
        pc_next       = 32'h0000_1000;
        for (int r = 0; r < (1 << RF_ADDR_W); r++) begin
            reg_model[r] = 32'd0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // quiet after reset
        @(negedge clk);
        checks++;
        assert (debug_wb_pc == 32'd0 && debug_wb_rf_wen == 4'd0 &&
                debug_wb_rf_wnum == '0 && debug_wb_rf_wdata == 32'd0) else begin
            errors++;
            $display("error at %0t: debug outputs not zero after reset", $time);
        end
        check_regs();

        // fill memory, then ordinary loads
        for (int i = 0; i < N_FILL; i++) begin
            issue(OP_SW, 32'(i * 4), $urandom(), $urandom(), $urandom_range(0, 31));
        end
        for (int i = 0; i < N_LOADS; i++) begin
            issue(lwb_op_e'($urandom_range(int'(OP_LB), int'(OP_LW))),
                  $urandom_range(0, 1023), $urandom(), $urandom(), $urandom_range(1, 31));
        end
        drain();

        // partial loads into preloaded registers
        for (int r = 16; r < 28; r++) begin
            issue(OP_ALU, 32'd0, $urandom(), 32'd0, r);
        end
        for (int a = 0; a < 4; a++) begin
            issue(OP_LWL, 32'h100 + a, $urandom(), 32'd0, 16 + a);
            issue(OP_LWR, 32'h104 + a, $urandom(), 32'd0, 20 + a);
            issue(OP_LWR, 32'h200 + a, $urandom(), 32'd0, 24 + a);  // unaligned word pair
            issue(OP_LWL, 32'h203 + a, $urandom(), 32'd0, 24 + a);
        end
        drain();
        check_regs();

        // alu pass-through, r0 included
        for (int r = 1; r < 6; r++) begin
            issue(OP_ALU, $urandom(), $urandom(), $urandom(), r);
        end
        issue(OP_ALU, 32'd0, 32'h1234_5678, 32'd0, 0);
        drain();
        check_regs();

        // back-to-back random mix
        for (int i = 0; i < N_MIX; i++) begin
            issue(lwb_op_e'($urandom_range(0, 9)), $urandom_range(0, 1023),
                  $urandom(), $urandom(), $urandom_range(0, 31));
        end
        drain();
        check_regs();

        checks++;
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d expected register writes never appeared in the trace", exp_q.size());
        end
        errors += load_wb_top_i.u_wb_stage.u_load_wb_chk.fail_cnt;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
hw/lwb_pkg.sv
hw/load_extend.sv
hw/mem_stage.sv
hw/data_ram.sv
hw/wb_stage.sv
hw/reg_file.sv
hw/load_wb_top.sv
tb/load_wb_chk.sv
tb/load_wb_tb.sv
